// File: cart_cfg.svh
`ifndef CART_CFG_SVH
`define CART_CFG_SVH

// ----------------------------------------
// Cartridge memory
// ----------------------------------------
`define CART_RAM_AW 12 // Word address bits.

// ----------------------------------------
// Console PI window
// ----------------------------------------
`define CART_PI_BASE_HI 16'h1000

// ----------------------------------------
// Host register space
// ----------------------------------------
`define CART_REG_SEL 15 // Host address bit.
`define CART_REG_GPIO_O 2'd0
`define CART_REG_GPIO_OE 2'd1
`define CART_REG_GPIO_I 2'd2

`endif

// File: cart_pkg.sv
`default_nettype none

`include "cart_cfg.svh"

package cart_pkg;

    // Memory opcode, one bit on the bus.
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    typedef struct packed {
        logic                    valid;
        mem_op_e                 op;
        logic [`CART_RAM_AW-1:0] addr; // Word address.
        logic [15:0]             data;
    } mem_req_t;

    typedef struct packed {
        logic        valid;
        logic [15:0] data;
    } mem_rsp_t;

    // PI bridge states.
    typedef enum logic [1:0] {
        PI_IDLE  = 2'd0,
        PI_FETCH = 2'd1,
        PI_READY = 2'd2,
        PI_WRITE = 2'd3
    } pi_state_e;

    typedef enum logic {
        OWNER_PI   = 1'b0,
        OWNER_HOST = 1'b1
    } arb_owner_e;

endpackage

`default_nettype wire

// File: cart_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "cart_cfg.svh"

module cart_ram import cart_pkg::*; (
    input  wire      i_clk,
    input  wire      mem_req_t i_req,
    output mem_rsp_t o_rsp
);

    localparam int DEPTH = 1 << `CART_RAM_AW;

    logic [15:0] mem [0:DEPTH-1];
    logic [15:0] rdata_q;
    logic        rd_vld_q;

    always_ff @(posedge i_clk) begin
        if (i_req.valid && i_req.op == MEM_WRITE) begin
            mem[i_req.addr] <= i_req.data;
        end
        rdata_q  <= mem[i_req.addr]; // Registered read port.
        rd_vld_q <= i_req.valid && (i_req.op == MEM_READ);
    end

    assign o_rsp.valid = rd_vld_q;
    assign o_rsp.data  = rdata_q;

endmodule

`default_nettype wire

// File: mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import cart_pkg::*; (
    input  wire      i_clk,
    input  wire      i_rst_n,

    input  wire      mem_req_t i_pi_req,
    output logic     o_pi_gnt,
    output mem_rsp_t o_pi_rsp,

    input  wire      mem_req_t i_host_req,
    output logic     o_host_gnt,
    output mem_rsp_t o_host_rsp
);

    arb_owner_e last_q; // Peer served last and owner of the pending read.
    logic       pick_pi;
    logic       pick_host;
    mem_req_t   ram_req;
    mem_rsp_t   ram_rsp;

    // ----------------------------------------
    // Round-robin grant
    // ----------------------------------------
    always_comb begin
        pick_pi   = i_pi_req.valid && (!i_host_req.valid || last_q == OWNER_HOST);
        pick_host = i_host_req.valid && !pick_pi;

        ram_req       = pick_pi ? i_pi_req : i_host_req;
        ram_req.valid = pick_pi || pick_host;
    end

    assign o_pi_gnt   = pick_pi;
    assign o_host_gnt = pick_host;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            last_q <= OWNER_PI;
        end else if (ram_req.valid) begin
            last_q <= pick_pi ? OWNER_PI : OWNER_HOST;
        end
    end

    cart_ram u_ram (
        .i_clk (i_clk),
        .i_req (ram_req),
        .o_rsp (ram_rsp)
    );

    // ----------------------------------------
    // Response steering
    // ----------------------------------------
    always_comb begin
        o_pi_rsp.data    = ram_rsp.data;
        o_host_rsp.data  = ram_rsp.data;
        o_pi_rsp.valid   = ram_rsp.valid && (last_q == OWNER_PI);
        o_host_rsp.valid = ram_rsp.valid && (last_q == OWNER_HOST);
    end

endmodule

`default_nettype wire

// File: n64_pi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "cart_cfg.svh"

module n64_pi_bridge import cart_pkg::*; (
    input  wire        i_clk,
    input  wire        i_rst_n,

    input  wire        i_pi_alel,
    input  wire        i_pi_aleh,
    input  wire        i_pi_read,
    input  wire        i_pi_write,

    input  wire [15:0] i_pi_ad,
    output logic [15:0] o_pi_ad,
    output logic       o_pi_ad_oe,

    output mem_req_t   o_mem_req,
    input  wire        i_mem_gnt,
    input  wire        mem_rsp_t i_mem_rsp
);

    // Strobe order is {alel, aleh, read, write}.
    logic [3:0]  strb_m_q;
    logic [3:0]  strb_s_q;
    logic [3:0]  strb_d_q;
    logic [15:0] ad_m_q;
    logic [15:0] ad_s_q;

    logic        alel_fall;
    logic        aleh_fall;
    logic        read_rise;
    logic        write_rise;

    pi_state_e   state_q;
    logic        fetch_issued_q;
    logic [31:0] addr_q;
    logic [15:0] rdata_q;
    logic [15:0] wdata_q;
    logic        win_hit;

    // ----------------------------------------
    // Synchronizers and edge detect
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            strb_m_q <= 4'hf; // Idle high.
            strb_s_q <= 4'hf;
            strb_d_q <= 4'hf;
        end else begin
            strb_m_q <= {i_pi_alel, i_pi_aleh, i_pi_read, i_pi_write};
            strb_s_q <= strb_m_q;
            strb_d_q <= strb_s_q;
        end
    end

    always_ff @(posedge i_clk) begin
        ad_m_q <= i_pi_ad;
        ad_s_q <= ad_m_q;
    end

    assign alel_fall  = strb_d_q[3] && !strb_s_q[3];
    assign aleh_fall  = strb_d_q[2] && !strb_s_q[2];
    assign read_rise  = !strb_d_q[1] && strb_s_q[1];
    assign write_rise = !strb_d_q[0] && strb_s_q[0];

    assign win_hit = (addr_q[31:16] == `CART_PI_BASE_HI);

    // ----------------------------------------
    // Bridge FSM
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q        <= PI_IDLE;
            fetch_issued_q <= 1'b0;
            addr_q         <= 32'd0;
        end else begin
            case (state_q)
                PI_FETCH: begin
                    if (i_mem_gnt) fetch_issued_q <= 1'b1;
                    if (i_mem_rsp.valid) begin
                        state_q        <= PI_READY;
                        fetch_issued_q <= 1'b0;
                    end
                end
                PI_WRITE: begin
                    if (i_mem_gnt) begin
                        addr_q  <= addr_q + 32'd2;
                        state_q <= PI_FETCH; // Prefetch the next word.
                    end
                end
                default: ;
            endcase

            if (aleh_fall) addr_q[31:16] <= ad_s_q;

            if (alel_fall) begin
                addr_q[15:0]   <= ad_s_q;
                state_q        <= win_hit ? PI_FETCH : PI_IDLE;
                fetch_issued_q <= 1'b0;
            end else if (read_rise) begin
                addr_q         <= addr_q + 32'd2;
                state_q        <= win_hit ? PI_FETCH : PI_IDLE;
                fetch_issued_q <= 1'b0;
            end else if (write_rise) begin
                if (win_hit) begin
                    state_q <= PI_WRITE;
                end else begin
                    addr_q <= addr_q + 32'd2; // Dropped, address still moves.
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_q == PI_FETCH && i_mem_rsp.valid) rdata_q <= i_mem_rsp.data;
        if (write_rise) wdata_q <= ad_s_q;
    end

    always_comb begin
        o_mem_req.valid = (state_q == PI_FETCH && !fetch_issued_q) || (state_q == PI_WRITE);
        o_mem_req.op    = (state_q == PI_WRITE) ? MEM_WRITE : MEM_READ;
        o_mem_req.addr  = addr_q[`CART_RAM_AW:1]; // Byte to word.
        o_mem_req.data  = wdata_q;
    end

    assign o_pi_ad    = rdata_q;
    assign o_pi_ad_oe = win_hit && !strb_s_q[1];

endmodule

`default_nettype wire

// File: host_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "cart_cfg.svh"

module host_port import cart_pkg::*; (
    input  wire        i_clk,
    input  wire        i_rst_n,

    input  wire        i_host_rd,
    input  wire        i_host_wr,
    input  wire [15:0] i_host_addr,
    input  wire [15:0] i_host_wdata,
    output logic [15:0] o_host_rdata,
    output logic       o_host_valid,
    output logic       o_host_busy,

    output mem_req_t   o_mem_req,
    input  wire        i_mem_gnt,
    input  wire        mem_rsp_t i_mem_rsp,

    output logic       o_reg_wr,
    output logic [1:0] o_reg_idx,
    output logic [7:0] o_reg_wdata,
    input  wire [7:0]  i_gpio_o,
    input  wire [7:0]  i_gpio_oe,
    input  wire [7:0]  i_gpio_in
);

    logic                    reg_sel;
    logic                    mem_acc;
    logic                    req_vld_q;
    mem_op_e                 req_op_q;
    logic [`CART_RAM_AW-1:0] req_addr_q;
    logic [15:0]             req_data_q;
    logic                    rd_out_q;  // Read granted, data not back yet.
    logic                    reg_vld_q;
    logic [15:0]             reg_rdata_q;
    logic [7:0]              reg_mux;

    assign reg_sel = i_host_addr[`CART_REG_SEL];
    assign mem_acc = (i_host_rd || i_host_wr) && !reg_sel;

    // ----------------------------------------
    // Memory path
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            req_vld_q <= 1'b0;
            rd_out_q  <= 1'b0;
        end else begin
            if (mem_acc) begin
                req_vld_q <= 1'b1;
            end else if (i_mem_gnt) begin
                req_vld_q <= 1'b0;
            end

            if (i_mem_gnt && req_op_q == MEM_READ) begin
                rd_out_q <= 1'b1;
            end else if (i_mem_rsp.valid) begin
                rd_out_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (mem_acc) begin
            req_op_q   <= i_host_wr ? MEM_WRITE : MEM_READ;
            req_addr_q <= i_host_addr[`CART_RAM_AW-1:0];
            req_data_q <= i_host_wdata;
        end
    end

    always_comb begin
        o_mem_req.valid = req_vld_q;
        o_mem_req.op    = req_op_q;
        o_mem_req.addr  = req_addr_q;
        o_mem_req.data  = req_data_q;
    end

    // ----------------------------------------
    // Register path
    // ----------------------------------------
    assign o_reg_wr    = i_host_wr && reg_sel;
    assign o_reg_idx   = i_host_addr[1:0];
    assign o_reg_wdata = i_host_wdata[7:0];

    always_comb begin
        case (i_host_addr[1:0])
            `CART_REG_GPIO_O:  reg_mux = i_gpio_o;
            `CART_REG_GPIO_OE: reg_mux = i_gpio_oe;
            `CART_REG_GPIO_I:  reg_mux = i_gpio_in;
            default:           reg_mux = 8'h00;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            reg_vld_q <= 1'b0;
        end else begin
            reg_vld_q <= i_host_rd && reg_sel;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_host_rd && reg_sel) reg_rdata_q <= {8'h00, reg_mux};
    end

    // Return data from either path.
    assign o_host_valid = reg_vld_q || (rd_out_q && i_mem_rsp.valid);
    assign o_host_rdata = reg_vld_q ? reg_rdata_q : i_mem_rsp.data;
    assign o_host_busy  = req_vld_q || rd_out_q;

endmodule

`default_nettype wire

// File: gpio_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cart_cfg.svh"

module gpio_ctrl (
    input  wire        i_clk,
    input  wire        i_rst_n,

    input  wire        i_reg_wr,
    input  wire [1:0]  i_reg_idx,
    input  wire [7:0]  i_reg_wdata,

    input  wire        i_n64_nmi,
    input  wire        i_n64_reset,

    output logic [7:0] o_gpio_o,
    output logic [7:0] o_gpio_oe,
    output logic [7:0] o_gpio_in,

    output wire        o_led,
    output wire        o_n64_irq
);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_gpio_o  <= 8'h00;
            o_gpio_oe <= 8'h00; // Pins float.
        end else if (i_reg_wr) begin
            if (i_reg_idx == `CART_REG_GPIO_O) o_gpio_o <= i_reg_wdata;
            if (i_reg_idx == `CART_REG_GPIO_OE) o_gpio_oe <= i_reg_wdata;
        end
    end

    // Tri-state pin drive.
    assign o_led     = o_gpio_oe[0] ? o_gpio_o[0] : 1'bz;
    assign o_n64_irq = o_gpio_oe[1] ? o_gpio_o[1] : 1'bz;

    // Sampled pin levels, read back from the pads.
    always_ff @(posedge i_clk) begin
        o_gpio_in <= {4'b0000, i_n64_nmi, i_n64_reset, o_n64_irq, o_led};
    end

endmodule

`default_nettype wire

// File: cart_top.sv
`timescale 1ns/1ps
`default_nettype none

module cart_top import cart_pkg::*; (
    input  wire        i_clk,
    input  wire        i_rst_n,

    input  wire        i_pi_alel,
    input  wire        i_pi_aleh,
    input  wire        i_pi_read,
    input  wire        i_pi_write,
    input  wire [15:0] i_pi_ad,
    output wire [15:0] o_pi_ad,
    output wire        o_pi_ad_oe,

    input  wire        i_host_rd,
    input  wire        i_host_wr,
    input  wire [15:0] i_host_addr,
    input  wire [15:0] i_host_wdata,
    output wire [15:0] o_host_rdata,
    output wire        o_host_valid,
    output wire        o_host_busy,

    input  wire        i_n64_nmi,
    input  wire        i_n64_reset,
    output wire        o_led,
    output wire        o_n64_irq
);

    mem_req_t   pi_req;
    mem_rsp_t   pi_rsp;
    logic       pi_gnt;
    mem_req_t   host_req;
    mem_rsp_t   host_rsp;
    logic       host_gnt;

    logic       reg_wr;
    logic [1:0] reg_idx;
    logic [7:0] reg_wdata;
    logic [7:0] gpio_o;
    logic [7:0] gpio_oe;
    logic [7:0] gpio_in;

    n64_pi_bridge u_pi (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_pi_alel  (i_pi_alel),
        .i_pi_aleh  (i_pi_aleh),
        .i_pi_read  (i_pi_read),
        .i_pi_write (i_pi_write),
        .i_pi_ad    (i_pi_ad),
        .o_pi_ad    (o_pi_ad),
        .o_pi_ad_oe (o_pi_ad_oe),
        .o_mem_req  (pi_req),
        .i_mem_gnt  (pi_gnt),
        .i_mem_rsp  (pi_rsp)
    );

    host_port u_host (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_host_rd    (i_host_rd),
        .i_host_wr    (i_host_wr),
        .i_host_addr  (i_host_addr),
        .i_host_wdata (i_host_wdata),
        .o_host_rdata (o_host_rdata),
        .o_host_valid (o_host_valid),
        .o_host_busy  (o_host_busy),
        .o_mem_req    (host_req),
        .i_mem_gnt    (host_gnt),
        .i_mem_rsp    (host_rsp),
        .o_reg_wr     (reg_wr),
        .o_reg_idx    (reg_idx),
        .o_reg_wdata  (reg_wdata),
        .i_gpio_o     (gpio_o),
        .i_gpio_oe    (gpio_oe),
        .i_gpio_in    (gpio_in)
    );

    mem_arbiter u_arb (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_pi_req   (pi_req),
        .o_pi_gnt   (pi_gnt),
        .o_pi_rsp   (pi_rsp),
        .i_host_req (host_req),
        .o_host_gnt (host_gnt),
        .o_host_rsp (host_rsp)
    );

    gpio_ctrl u_gpio (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_reg_wr    (reg_wr),
        .i_reg_idx   (reg_idx),
        .i_reg_wdata (reg_wdata),
        .i_n64_nmi   (i_n64_nmi),
        .i_n64_reset (i_n64_reset),
        .o_gpio_o    (gpio_o),
        .o_gpio_oe   (gpio_oe),
        .o_gpio_in   (gpio_in),
        .o_led       (o_led),
        .o_n64_irq   (o_n64_irq)
    );

endmodule

`default_nettype wire

// File: tb_cart_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cart_cfg.svh"

module tb_cart_top;

    // Table opcodes.
    localparam logic [3:0] OP_HWR    = 4'd0; // Host write.
    localparam logic [3:0] OP_HRD    = 4'd1; // Host read.
    localparam logic [3:0] OP_PADDR  = 4'd2; // PI address latch.
    localparam logic [3:0] OP_PRD    = 4'd3; // PI read strobe.
    localparam logic [3:0] OP_PRD_BG = 4'd4; // PI read strobe, runs in the background.
    localparam logic [3:0] OP_PWR    = 4'd5; // PI write strobe.
    localparam logic [3:0] OP_PINS   = 4'd6; // Set nmi and reset pins.
    localparam logic [3:0] OP_PCHK   = 4'd7; // Check led and irq pins.
    localparam logic [3:0] OP_WAIT   = 4'd8;

    localparam int          MAX_ENTRIES = 128;
    localparam int          HOST_LIMIT  = 20;
    localparam logic [15:0] REG_BASE    = 16'h0001 << `CART_REG_SEL;

    typedef struct packed {
        logic [3:0]  op;
        logic [31:0] addr;
        logic [15:0] data;
        logic [15:0] exp;
        logic        chk; // PI access falls in the window.
    } entry_t;

    logic        clk;
    logic        rst_n;
    logic        pi_alel;
    logic        pi_aleh;
    logic        pi_read;
    logic        pi_write;
    logic [15:0] pi_ad_in;
    wire  [15:0] pi_ad_out;
    wire         pi_ad_oe;
    logic        host_rd;
    logic        host_wr;
    logic [15:0] host_addr;
    logic [15:0] host_wdata;
    wire  [15:0] host_rdata;
    wire         host_valid;
    wire         host_busy;
    logic        n64_nmi;
    logic        n64_reset;
    wire         led;
    wire         n64_irq;

    entry_t      tbl [0:MAX_ENTRIES-1];
    int          n_tbl = 0;
    logic        tbl_ready = 1'b0;
    logic [15:0] sb [0:(1 << `CART_RAM_AW)-1]; // Scoreboard by word address.
    logic [31:0] m_pi_addr;
    logic [7:0]  m_gpio_o;
    logic [7:0]  m_gpio_oe;
    logic        m_nmi;
    logic        m_rst;
    integer      seed = 32'hbe52;
    int          errors = 0;
    int          checks = 0;
    int          idx;
    logic        bg_req = 1'b0;
    logic [15:0] bg_exp;
    logic        bg_chk;

    cart_top DUT (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_pi_alel    (pi_alel),
        .i_pi_aleh    (pi_aleh),
        .i_pi_read    (pi_read),
        .i_pi_write   (pi_write),
        .i_pi_ad      (pi_ad_in),
        .o_pi_ad      (pi_ad_out),
        .o_pi_ad_oe   (pi_ad_oe),
        .i_host_rd    (host_rd),
        .i_host_wr    (host_wr),
        .i_host_addr  (host_addr),
        .i_host_wdata (host_wdata),
        .o_host_rdata (host_rdata),
        .o_host_valid (host_valid),
        .o_host_busy  (host_busy),
        .i_n64_nmi    (n64_nmi),
        .i_n64_reset  (n64_reset),
        .o_led        (led),
        .o_n64_irq    (n64_irq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // Expected value model
    // ----------------------------------------
    function automatic logic expected_led();
        return m_gpio_oe[0] ? m_gpio_o[0] : 1'bz;
    endfunction

    function automatic logic expected_irq();
        return m_gpio_oe[1] ? m_gpio_o[1] : 1'bz;
    endfunction

    function automatic logic [15:0] next_word();
        int r;
        r = $random(seed);
        return r[15:0];
    endfunction

    task automatic add_entry(input logic [3:0] op, input logic [31:0] addr,
                             input logic [15:0] data);
        entry_t e;
        e.op   = op;
        e.addr = addr;
        e.data = data;
        e.exp  = 16'h0000;
        e.chk  = 1'b1;
        case (op)
            OP_HWR: begin
                if (addr[`CART_REG_SEL]) begin
                    if (addr[1:0] == `CART_REG_GPIO_O) m_gpio_o = data[7:0];
                    if (addr[1:0] == `CART_REG_GPIO_OE) m_gpio_oe = data[7:0];
                end else begin
                    sb[addr[`CART_RAM_AW-1:0]] = data;
                end
            end
            OP_HRD: begin
                if (!addr[`CART_REG_SEL]) e.exp = sb[addr[`CART_RAM_AW-1:0]];
                else if (addr[1:0] == `CART_REG_GPIO_O) e.exp = {8'h00, m_gpio_o};
                else if (addr[1:0] == `CART_REG_GPIO_OE) e.exp = {8'h00, m_gpio_oe};
                else e.exp = {12'h000, m_nmi, m_rst, expected_irq(), expected_led()};
            end
            OP_PADDR: m_pi_addr = addr;
            OP_PRD, OP_PRD_BG: begin
                e.chk     = (m_pi_addr[31:16] == `CART_PI_BASE_HI);
                e.exp     = sb[m_pi_addr[`CART_RAM_AW:1]];
                m_pi_addr = m_pi_addr + 32'd2;
            end
            OP_PWR: begin
                if (m_pi_addr[31:16] == `CART_PI_BASE_HI) sb[m_pi_addr[`CART_RAM_AW:1]] = data;
                m_pi_addr = m_pi_addr + 32'd2; // Address moves even outside the window.
            end
            OP_PINS: begin
                m_nmi = data[1];
                m_rst = data[0];
            end
            OP_PCHK: e.exp = {14'h0000, expected_irq(), expected_led()};
            default: ;
        endcase
        tbl[n_tbl] = e;
        n_tbl++;
    endtask

    task automatic build_table();
        int k;
        m_gpio_o  = 8'h00;
        m_gpio_oe = 8'h00;
        m_nmi     = 1'b0;
        m_rst     = 1'b0;

        // Host block, PI reads it back.
        for (k = 0; k < 8; k++) add_entry(OP_HWR, 32'h0040 + k, next_word());
        add_entry(OP_PADDR, {`CART_PI_BASE_HI, 16'h0080}, 16'h0000);
        for (k = 0; k < 8; k++) add_entry(OP_PRD, 32'h0, 16'h0000);

        // PI burst, host reads it back.
        add_entry(OP_PADDR, {`CART_PI_BASE_HI, 16'h0200}, 16'h0000);
        for (k = 0; k < 6; k++) add_entry(OP_PWR, 32'h0, next_word());
        for (k = 0; k < 6; k++) add_entry(OP_HRD, 32'h0100 + k, 16'h0000);

        // Outside the window.
        add_entry(OP_PADDR, 32'h2000_0080, 16'h0000);
        add_entry(OP_PRD, 32'h0, 16'h0000);
        add_entry(OP_PRD, 32'h0, 16'h0000);
        add_entry(OP_PWR, 32'h0, next_word());
        add_entry(OP_HRD, 32'h0042, 16'h0000);
        add_entry(OP_HRD, 32'h0043, 16'h0000);

        // ----------------------------------------
        // GPIO registers and pins
        // ----------------------------------------
        add_entry(OP_PCHK, 32'h0, 16'h0000);
        add_entry(OP_HWR, REG_BASE | `CART_REG_GPIO_O, 16'h0003);
        add_entry(OP_PCHK, 32'h0, 16'h0000);
        add_entry(OP_HWR, REG_BASE | `CART_REG_GPIO_OE, 16'h0001);
        add_entry(OP_PCHK, 32'h0, 16'h0000);
        add_entry(OP_HWR, REG_BASE | `CART_REG_GPIO_O, 16'h0002);
        add_entry(OP_PCHK, 32'h0, 16'h0000);
        add_entry(OP_HWR, REG_BASE | `CART_REG_GPIO_OE, 16'h0003);
        add_entry(OP_PCHK, 32'h0, 16'h0000);
        add_entry(OP_HRD, REG_BASE | `CART_REG_GPIO_O, 16'h0000);
        add_entry(OP_HRD, REG_BASE | `CART_REG_GPIO_OE, 16'h0000);
        add_entry(OP_PINS, 32'h0, 16'h0002);
        add_entry(OP_HRD, REG_BASE | `CART_REG_GPIO_I, 16'h0000);
        add_entry(OP_PINS, 32'h0, 16'h0001);
        add_entry(OP_HRD, REG_BASE | `CART_REG_GPIO_I, 16'h0000);

        // Host reads racing a PI read burst.
        for (k = 0; k < 12; k++) add_entry(OP_HWR, 32'h0200 + k, next_word());
        add_entry(OP_PADDR, {`CART_PI_BASE_HI, 16'h0400}, 16'h0000);
        for (k = 0; k < 8; k++) begin
            add_entry(OP_PRD_BG, 32'h0, 16'h0000);
            add_entry(OP_WAIT, 32'h0, k);
            add_entry(OP_HRD, 32'h020b - k, 16'h0000);
            add_entry(OP_HRD, 32'h0040 + k, 16'h0000);
            add_entry(OP_HRD, 32'h0100 + (k % 6), 16'h0000);
        end
    endtask

    // ----------------------------------------
    // Bus drivers and checks
    // ----------------------------------------
    task automatic compare_hex(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic host_access(input logic wr, input logic [15:0] addr,
                               input logic [15:0] data, input logic [15:0] exp);
        int n;
        @(posedge clk);
        host_addr  <= addr;
        host_wdata <= data;
        host_rd    <= !wr;
        host_wr    <= wr;
        @(posedge clk);
        host_rd <= 1'b0;
        host_wr <= 1'b0;
        @(negedge clk);
        if (!wr) begin
            n = 0;
            while (!host_valid && n < HOST_LIMIT) begin
                @(negedge clk);
                n++;
            end
            checks++;
            assert (host_valid) else begin
                errors++;
                $display("Host read at %h returned no valid pulse", addr);
            end
            if (host_valid) compare_hex("o_host_rdata", host_rdata, exp);
        end
        n = 0;
        while (host_busy && n < HOST_LIMIT) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (!host_busy) else begin
            errors++;
            $display("Host busy stayed high after the access at %h", addr);
        end
    endtask

    task automatic pi_address(input logic [31:0] addr);
        @(posedge clk);
        pi_ad_in <= addr[31:16];
        pi_aleh  <= 1'b0;
        repeat (8) @(posedge clk);
        pi_aleh  <= 1'b1;
        repeat (8) @(posedge clk);
        pi_ad_in <= addr[15:0];
        pi_alel  <= 1'b0;
        repeat (8) @(posedge clk);
        pi_alel  <= 1'b1;
        repeat (8) @(posedge clk);
    endtask

    task automatic pi_read_strobe(input logic [15:0] exp, input logic win);
        int k;
        @(posedge clk);
        pi_read <= 1'b0;
        for (k = 0; k < 8; k++) begin
            @(negedge clk);
            // Enable rises after the synchronizer delay.
            if (!win || k >= 3) begin
                compare_hex("o_pi_ad_oe", {15'h0000, pi_ad_oe}, {15'h0000, win});
            end
        end
        if (win) compare_hex("o_pi_ad", pi_ad_out, exp);
        @(posedge clk);
        pi_read <= 1'b1;
        repeat (8) @(posedge clk);
    endtask

    task automatic pi_write_strobe(input logic [15:0] data);
        @(posedge clk);
        pi_ad_in <= data;
        pi_write <= 1'b0;
        repeat (8) @(posedge clk);
        pi_write <= 1'b1;
        repeat (8) @(posedge clk);
    endtask

    task automatic run_entry(input entry_t e);
        case (e.op)
            OP_HWR: host_access(1'b1, e.addr[15:0], e.data, e.exp);
            OP_HRD: host_access(1'b0, e.addr[15:0], e.data, e.exp);
            OP_PADDR: begin
                wait (!bg_req);
                pi_address(e.addr);
            end
            OP_PRD: begin
                wait (!bg_req);
                pi_read_strobe(e.exp, e.chk);
            end
            OP_PRD_BG: begin
                wait (!bg_req);
                bg_exp = e.exp;
                bg_chk = e.chk;
                bg_req = 1'b1;
            end
            OP_PWR: begin
                wait (!bg_req);
                pi_write_strobe(e.data);
            end
            OP_PINS: begin
                @(posedge clk);
                n64_nmi   <= e.data[1];
                n64_reset <= e.data[0];
                repeat (3) @(posedge clk); // Let the input register sample.
            end
            OP_PCHK: begin
                @(negedge clk);
                compare_hex("o_led", {15'h0000, led}, {15'h0000, e.exp[0]});
                compare_hex("o_n64_irq", {15'h0000, n64_irq}, {15'h0000, e.exp[1]});
            end
            OP_WAIT: repeat (e.data) @(posedge clk);
            default: ;
        endcase
    endtask

    // Background PI reader for the racing sequence.
    initial begin
        forever begin
            wait (bg_req);
            pi_read_strobe(bg_exp, bg_chk);
            bg_req = 1'b0;
        end
    end

    initial begin
        wait (tbl_ready);
        repeat ((n_tbl + 1) * 40) @(posedge clk);
        $display("Watchdog expired before the test sequence finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        rst_n      = 1'b0;
        pi_alel    = 1'b1;
        pi_aleh    = 1'b1;
        pi_read    = 1'b1;
        pi_write   = 1'b1;
        pi_ad_in   = 16'h0000;
        host_rd    = 1'b0;
        host_wr    = 1'b0;
        host_addr  = 16'h0000;
        host_wdata = 16'h0000;
        n64_nmi    = 1'b0;
        n64_reset  = 1'b0;

        build_table();
        tbl_ready = 1'b1;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        for (idx = 0; idx < n_tbl; idx++) run_entry(tbl[idx]);
        wait (!bg_req);
        repeat (4) @(posedge clk);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
cart_pkg.sv
cart_ram.sv
mem_arbiter.sv
n64_pi_bridge.sv
host_port.sv
gpio_ctrl.sv
cart_top.sv
tb_cart_top.sv

// File: Bender.yml
package:
  name: cart_top

sources:
  - include_dirs:
      - .
    files:
      - cart_pkg.sv
      - cart_ram.sv
      - mem_arbiter.sv
      - n64_pi_bridge.sv
      - host_port.sv
      - gpio_ctrl.sv
      - cart_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cart_top.sv
